// ==== agnus_tests.txt ====
// cycle vectors, all values hex, first word is the vector count
// cycles bus req busy zero bls turbo | owner dbr dbwe address reg data ena_blt sol strobes
// bus {aen,rd,hwr,lwr,reg,data}  req {dsk,aud,bpl,spr,cop,blt,dsk_wr,blt_we}
// strobes {denise,paula}; inputs held for cycles, outputs checked in the last
2B
1 C010000 00 1 1 0 0  7 0 0 00000 01 6000 0 0 0
1 0000000 40 0 0 0 0  1 1 0 00000 FF 0000 0 0 0
1 0000000 40 0 0 0 0  2 1 0 20B00 50 0000 0 0 0
1 0000000 C2 0 0 0 0  0 1 1 10A00 20 0000 0 0 0
1 B4B83E0 3C 0 0 0 0  7 0 0 00000 4B 0000 0 0 0
1 C010000 00 0 0 0 0  1 1 0 00000 FF 0000 0 0 0
1 C010000 00 0 0 0 0  7 0 0 00000 01 03E0 1 0 0
1 0000000 7C 0 0 0 0  1 1 0 00000 FF 0000 0 0 0
1 0000000 3C 0 0 0 0  3 1 0 30C00 88 0000 0 0 0
1 0000000 1C 0 0 0 0  4 1 0 40D00 A0 0000 0 0 0
1 0000000 0C 0 0 0 0  5 1 0 50E00 44 0000 0 0 0
1 0000000 07 0 0 0 0  6 1 1 60F00 37 0000 1 0 2
1 0000000 43 0 0 0 0  2 1 0 20B00 50 0000 0 0 0
1 0000000 06 0 0 0 0  6 1 0 60F00 37 0000 1 0 1
1 B4B00A0 00 0 0 0 0  7 0 0 00000 4B 0000 1 0 0
1 C010000 00 0 0 0 0  7 0 0 00000 01 0340 1 0 0
1 0000000 1C 0 0 0 0  6 1 0 60F00 37 0000 1 0 0
1 B4B0200 00 0 0 0 0  7 0 0 00000 4B 0000 1 0 0
1 0000000 3C 0 0 0 0  7 0 0 00000 FF 0000 0 0 0
1 B4B8200 00 0 0 0 0  7 0 0 00000 4B 0000 0 0 0
// slowdown, counted on even slots
1 0000000 04 0 0 1 0  6 1 0 60F00 37 0000 1 0 0
1 0000000 04 0 0 1 0  6 1 0 60F00 37 0000 1 0 0
1 0000000 04 0 0 1 0  6 1 0 60F00 37 0000 1 0 0
1 0000000 04 0 0 1 0  6 1 0 60F00 37 0000 1 0 0
1 0000000 04 0 0 1 0  6 1 0 60F00 37 0000 1 0 0
1 0000000 04 0 0 1 0  7 0 0 00000 FF 0000 0 0 0
1 0000000 04 0 0 1 0  7 0 0 00000 FF 0000 0 0 0
1 0000000 04 0 0 0 0  7 0 0 00000 FF 0000 0 0 0
1 0000000 04 0 0 0 0  7 0 0 00000 FF 0000 0 0 0
1 0000000 04 0 0 1 0  6 1 0 60F00 37 0000 1 0 0
1 0000000 04 0 0 1 0  6 1 0 60F00 37 0000 1 0 0
1 0000000 04 0 0 1 1  6 1 0 60F00 37 0000 1 0 0
1 0000000 04 0 0 1 1  6 1 0 60F00 37 0000 1 0 0
1 0000000 04 0 0 1 1  7 0 0 00000 FF 0000 0 0 0
1 B4B8400 04 0 0 1 1  7 0 0 00000 4B 0000 0 0 0
1 0000000 04 0 0 1 1  7 0 0 00000 FF 0000 0 0 0
1 0000000 04 0 0 1 1  6 1 0 60F00 37 0000 1 0 0
1 0000000 04 0 0 1 1  6 1 0 60F00 37 0000 1 0 0
1 C010000 00 1 0 0 0  7 0 0 00000 01 4740 1 0 0
// run to the end of the line and wrap
BB 0000000 00 0 0 0 0 7 0 0 00000 FF 0000 1 0 0
1 0000000 00 0 0 0 0  7 0 0 00000 FF 0000 1 1 0
1 0000000 40 0 0 0 0  2 1 0 20B00 50 0000 0 0 0
1 0000000 40 0 0 0 0  1 1 0 00000 FF 0000 0 0 0

// ==== build.f ====
+incdir+.
agnus_pkg.sv
beam_counter.sv
dma_control.sv
blitter_slowdown.sv
bus_arbiter.sv
agnus_dma_core.sv
tb_agnus.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the agnus dma core

TOP = tb_agnus

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f $(wildcard *.sv *.svh)
	verilator --binary --assert -Wno-fatal -f build.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Regression failed" sim.log || ! grep -q "Regression passed" sim.log; then \
		echo "simulation FAILED"; exit 1; \
	fi
	@echo "simulation ok"

lint:
	verilator --lint-only -Wall -f build.f --top-module agnus_dma_core

clean:
	rm -rf obj_dir sim.log

// ==== tb_agnus.sv ====
/*
  testbench for the agnus dma core
  replays the cycle vectors one bus cycle at a time, inputs on the
  falling edge, outputs compared just before the next rising edge
*/
`timescale 1ns/1ns
`default_nettype none
`include "agnus_cfg.svh"

module tb_agnus;

  localparam int NF      = 16;                  // words per vector
  localparam int MAX_VEC = 64;
  localparam int MEM_W   = 1 + NF * MAX_VEC;    // count word plus vectors

  logic                    clk;
  logic                    reset;
  agnus_pkg::cpu_bus_t     bus;
  agnus_pkg::dma_req_t     req;
  agnus_pkg::engine_addr_t addr;
  logic                    blit_busy;
  logic                    blit_zero;
  logic                    bls;
  logic                    turbo;
  agnus_pkg::bus_grant_t   grant;
  logic [19:0]             address_out;
  logic [7:0]              reg_address_out;
  logic [15:0]             data_out;
  logic                    bltpri;
  logic                    ena_cop;
  logic                    ena_blt;
  logic                    sol;
  logic                    strhor_denise;
  logic                    strhor_paula;

  logic [31:0] vec_mem [MEM_W];                 // raw words from the vector file
  int          n_vec;
  int          limit = 0;                       // cycle limit, 0 until loaded
  int          cycles = 0;
  logic        nasty_exp;                       // expected dmacon nasty bit

  agnus_dma_core dut_i (
    .clk            (clk),
    .reset          (reset),
    .bus            (bus),
    .req            (req),
    .addr           (addr),
    .blit_busy      (blit_busy),
    .blit_zero      (blit_zero),
    .bls            (bls),
    .turbo          (turbo),
    .grant          (grant),
    .address_out    (address_out),
    .reg_address_out(reg_address_out),
    .data_out       (data_out),
    .bltpri         (bltpri),
    .ena_cop        (ena_cop),
    .ena_blt        (ena_blt),
    .sol            (sol),
    .strhor_denise  (strhor_denise),
    .strhor_paula   (strhor_paula)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_run($sformatf("CHECK FAILED at %0t ns: %s expected %0h got %0h",
                         $time, name, expected, actual));
    end
  endtask

  function automatic logic [31:0] vector_word(input int v, input int k);
    return vec_mem[1 + v * NF + k];
  endfunction

  // unloaded words keep a marker above any legal field (widest is 28 bits)
  task automatic load_vectors();
    int fd;
    int i;
    int total;
    fd = $fopen("agnus_tests.txt", "r");
    if (fd == 0) stop_run("vector file agnus_tests.txt is missing");
    $fclose(fd);
    for (i = 0; i < MEM_W; i++) vec_mem[i] = 32'hF000_0000 | i;
    $readmemh("agnus_tests.txt", vec_mem);
    n_vec = vec_mem[0];
    if (vec_mem[0] >= 32'h1000_0000 || n_vec <= 0 || n_vec > MAX_VEC)
      stop_run("vector file has no usable vector count");
    total = 0;
    for (i = 1; i <= n_vec * NF; i++) begin
      if (vec_mem[i] >= 32'h1000_0000) stop_run("vector file is shorter than its count");
    end
    for (i = 0; i < n_vec; i++) total += vector_word(i, 0);
    limit = 2 * total + 20;
  endtask

  // --------------------
  task automatic drive_vector(input int v);
    logic [31:0] w;
    w = vector_word(v, 1);
    bus = w[27:0];
    w = vector_word(v, 2);
    req = w[7:0];
    w = vector_word(v, 3);
    blit_busy = w[0];
    w = vector_word(v, 4);
    blit_zero = w[0];
    w = vector_word(v, 5);
    bls = w[0];
    w = vector_word(v, 6);
    turbo = w[0];
  endtask

  // nasty bit follows dmacon writes that reach the register in this slot
  task automatic track_nasty(input int v);
    logic [31:0] reg_w;
    logic [31:0] bus_w;
    reg_w = vector_word(v, 11);
    bus_w = vector_word(v, 1);
    if (reg_w[7:0] == `AGNUS_REG_DMACON && bus_w[`AGNUS_DMA_BLTPRI]) begin
      nasty_exp = bus_w[`AGNUS_DMA_SETCLR];
    end
  endtask

  // acks, cpu_custom and ena_cop follow from the expected owner alone
  task automatic compare_outputs(input int v);
    logic [31:0]      w;
    agnus_pkg::chan_e own;
    w = vector_word(v, 7);
    own = agnus_pkg::chan_e'(w[2:0]);
    check_value("owner", 32'(grant.owner), w);
    check_value("cpu_custom", 32'(grant.cpu_custom), 32'(own == agnus_pkg::CH_CPU));
    check_value("dbr", 32'(grant.dbr), vector_word(v, 8));
    check_value("dbwe", 32'(grant.dbwe), vector_word(v, 9));
    check_value("ack_spr", 32'(grant.ack_spr), 32'(own == agnus_pkg::CH_SPR));
    check_value("ack_cop", 32'(grant.ack_cop), 32'(own == agnus_pkg::CH_COP));
    check_value("ack_blt", 32'(grant.ack_blt), 32'(own == agnus_pkg::CH_BLT));
    check_value("address_out", 32'(address_out), vector_word(v, 10));
    check_value("reg_address_out", 32'(reg_address_out), vector_word(v, 11));
    check_value("data_out", 32'(data_out), vector_word(v, 12));
    check_value("ena_cop", 32'(ena_cop), 32'(own != agnus_pkg::CH_BPL));
    check_value("ena_blt", 32'(ena_blt), vector_word(v, 13));
    check_value("bltpri", 32'(bltpri), 32'(nasty_exp));
    check_value("sol", 32'(sol), vector_word(v, 14));
    check_value("strobes", 32'({strhor_denise, strhor_paula}), vector_word(v, 15));
  endtask

  // --------------------
  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles > limit) stop_run("timeout, vectors did not finish in time");
  end

  initial begin
    int v;
    int r;
    int n;
    reset = 1'b1;
    bus = '0;
    req = '0;
    blit_busy = 1'b0;
    blit_zero = 1'b0;
    bls = 1'b0;
    turbo = 1'b0;
    nasty_exp = 1'b0;
    // engine addresses, distinct per channel, none hits dmacon
    addr.dsk = '{address: 20'h10A00, reg_address: 8'h20};
    addr.aud = '{address: 20'h20B00, reg_address: 8'h50};
    addr.bpl = '{address: 20'h30C00, reg_address: 8'h88};
    addr.spr = '{address: 20'h40D00, reg_address: 8'hA0};
    addr.cop = '{address: 20'h50E00, reg_address: 8'h44};
    addr.blt = '{address: 20'h60F00, reg_address: 8'h37};
    load_vectors();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;                               // first vector sees hpos 0
    for (v = 0; v < n_vec; v++) begin
      n = vector_word(v, 0);
      for (r = 0; r < n; r++) begin
        drive_vector(v);
        if (r == n - 1) begin
          #4;                                   // 1 ns before the rising edge
          compare_outputs(v);
        end
        track_nasty(v);                         // write lands on the coming edge
        @(negedge clk);
      end
    end
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== agnus_dma_core.sv ====
/*
  agnus dma core
  bus slot side of the address generator: beam counter, dmacon,
  blitter slowdown and the slot arbiter around the cpu register decode
*/
`timescale 1ns/1ns
`default_nettype none
`include "agnus_cfg.svh"

module agnus_dma_core (
  input  logic                    clk,
  input  logic                    reset,
  input  agnus_pkg::cpu_bus_t     bus,
  input  agnus_pkg::dma_req_t     req,
  input  agnus_pkg::engine_addr_t addr,
  input  logic                    blit_busy,
  input  logic                    blit_zero,
  input  logic                    bls,              // cpu waiting for bus
  input  logic                    turbo,
  output agnus_pkg::bus_grant_t   grant,
  output logic [19:0]             address_out,
  output logic [7:0]              reg_address_out,
  output logic [15:0]             data_out,
  output logic                    bltpri,
  output logic                    ena_cop,
  output logic                    ena_blt,
  output logic                    sol,
  output logic                    strhor_denise,
  output logic                    strhor_paula
);

  logic                    cck;
  logic                    refresh;
  logic                    blt_blocked;
  logic [7:0]              cpu_reg_address;
  agnus_pkg::dma_enables_t enables;

  // cpu register address only while a real access is on the bus
  assign cpu_reg_address = (bus.aen & (bus.rd | bus.hwr | bus.lwr)) ? bus.address
                                                                    : `AGNUS_REG_IDLE;
  assign bltpri = enables.bltpri;

  // --------------------
  beam_counter beam_i (
    .clk          (clk),
    .reset        (reset),
    .hpos         (),                  // slot position decoded inside
    .cck          (cck),
    .refresh      (refresh),
    .sol          (sol),
    .strhor_denise(strhor_denise),
    .strhor_paula (strhor_paula)
  );

  dma_control dmacon_i (
    .clk        (clk),
    .reset      (reset),
    .reg_address(reg_address_out),     // written from whoever owns the slot
    .data_in    (bus.data),
    .blit_busy  (blit_busy),
    .blit_zero  (blit_zero),
    .enables    (enables),
    .data_out   (data_out)
  );

  blitter_slowdown bls_i (
    .clk        (clk),
    .reset      (reset),
    .cck        (cck),
    .turbo      (turbo),
    .bls        (bls),
    .bltpri     (bltpri),
    .blt_blocked(blt_blocked)
  );

  // --------------------
  bus_arbiter arb_i (
    .req            (req),
    .addr           (addr),
    .refresh        (refresh),
    .enables        (enables),
    .blt_blocked    (blt_blocked),
    .cpu_reg_address(cpu_reg_address),
    .grant          (grant),
    .address_out    (address_out),
    .reg_address    (reg_address_out),
    .ena_cop        (ena_cop),
    .ena_blt        (ena_blt)
  );

endmodule

`default_nettype wire

// ==== bus_arbiter.sv ====
/*
  bus slot arbiter
  fixed priority owner selection, chip/register address mux,
  acknowledges and the copper/blitter enables
*/
`timescale 1ns/1ns
`default_nettype none
`include "agnus_cfg.svh"

module bus_arbiter (
  input  agnus_pkg::dma_req_t     req,
  input  agnus_pkg::engine_addr_t addr,
  input  logic                    refresh,          // fixed refresh slot
  input  agnus_pkg::dma_enables_t enables,
  input  logic                    blt_blocked,      // slowdown holds blitter
  input  logic [7:0]              cpu_reg_address,
  output agnus_pkg::bus_grant_t   grant,
  output logic [19:0]             address_out,
  output logic [7:0]              reg_address,
  output logic                    ena_cop,
  output logic                    ena_blt
);

  logic                  dma_bpl;                   // requests after enable gating
  logic                  dma_spr;
  logic                  dma_cop;
  logic                  dma_blt;
  agnus_pkg::chan_e      owner;
  agnus_pkg::chan_addr_t sel;                       // winning address pair

  assign dma_bpl = req.bpl & enables.bpl;
  assign dma_spr = req.spr & enables.spr;
  assign dma_cop = req.cop & enables.cop;
  assign dma_blt = req.blt & enables.blt & ~blt_blocked;

  // --------------------
  // priority chain, first hit wins
  always_comb begin
    if (req.dsk)          owner = agnus_pkg::CH_DSK;
    else if (refresh)     owner = agnus_pkg::CH_REF;
    else if (req.aud)     owner = agnus_pkg::CH_AUD;
    else if (dma_bpl)     owner = agnus_pkg::CH_BPL;
    else if (dma_spr)     owner = agnus_pkg::CH_SPR;
    else if (dma_cop)     owner = agnus_pkg::CH_COP;
    else if (dma_blt)     owner = agnus_pkg::CH_BLT;
    else                  owner = agnus_pkg::CH_CPU;   // slot left to cpu
  end

  // --------------------
  // address mux
  always_comb begin
    case (owner)
      agnus_pkg::CH_DSK: sel = addr.dsk;
      agnus_pkg::CH_REF: sel = '{address: '0, reg_address: `AGNUS_REG_IDLE};
      agnus_pkg::CH_AUD: sel = addr.aud;
      agnus_pkg::CH_BPL: sel = addr.bpl;
      agnus_pkg::CH_SPR: sel = addr.spr;
      agnus_pkg::CH_COP: sel = addr.cop;
      agnus_pkg::CH_BLT: sel = addr.blt;
      default:           sel = '{address: '0, reg_address: cpu_reg_address};  // cpu
    endcase
  end

  assign address_out = sel.address;
  assign reg_address = sel.reg_address;

  // --------------------
  // control lines and acknowledges
  always_comb begin
    grant.owner      = owner;
    grant.cpu_custom = (owner == agnus_pkg::CH_CPU);
    grant.dbr        = (owner != agnus_pkg::CH_CPU);
    // only disk and blitter ever write memory
    grant.dbwe       = ((owner == agnus_pkg::CH_DSK) & req.dsk_wr)
                     | ((owner == agnus_pkg::CH_BLT) & req.blt_we);
    grant.ack_spr    = (owner == agnus_pkg::CH_SPR);
    grant.ack_cop    = (owner == agnus_pkg::CH_COP);
    grant.ack_blt    = (owner == agnus_pkg::CH_BLT);
    // separately decoded blitter enable must agree with the chain
    blt_ena_match: assert #0 (grant.ack_blt == (req.blt & ena_blt))
      else $error("blitter enable disagrees with slot owner");
  end

  // copper can only be pushed out by bitplane fetches
  assign ena_cop = (owner != agnus_pkg::CH_BPL);
  // blitter runs when nothing above it uses the slot
  assign ena_blt = enables.blt & ~blt_blocked
                 & ~(req.dsk | refresh | req.aud | dma_bpl | dma_spr | dma_cop);

endmodule

`default_nettype wire

// ==== blitter_slowdown.sv ====
/*
  blitter slowdown
  counts memory cycles the cpu loses while waiting for the bus and
  blocks the blitter once the limit is hit
*/
`timescale 1ns/1ns
`default_nettype none
`include "agnus_cfg.svh"

module blitter_slowdown (
  input  logic clk,
  input  logic reset,
  input  logic cck,          // colour clock phase, counted on low phase
  input  logic turbo,        // count on every cycle
  input  logic bls,          // cpu is waiting for the bus
  input  logic bltpri,       // blitter nasty, never slow down
  output logic blt_blocked
);

  localparam int CNT_W = $clog2(`AGNUS_BLS_CNT_MAX + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`AGNUS_BLS_CNT_MAX);

  logic [CNT_W-1:0] bls_cnt;   // cpu-lost cycles so far
  logic             cnt_en;

  assign cnt_en = !cck || turbo;

  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      bls_cnt <= '0;
    end else if (cnt_en) begin
      if (!bls || bltpri) begin
        bls_cnt <= '0;                      // cpu got through or nasty mode
      end else if (bls_cnt != CNT_MAX) begin
        bls_cnt <= bls_cnt + 1'b1;          // saturate at limit
      end
    end
  end

  assign blt_blocked = (bls_cnt == CNT_MAX);

  // once saturated the count holds while the cpu keeps waiting
  cnt_saturates: assert property (@(posedge clk) disable iff (reset)
    blt_blocked && bls && !bltpri |=> blt_blocked)
    else $error("slowdown counter left its limit");

endmodule

`default_nettype wire

// ==== dma_control.sv ====
/*
  dma control register
  set/clear write, read-back with blitter status and the
  master-qualified channel enables
*/
`timescale 1ns/1ns
`default_nettype none
`include "agnus_cfg.svh"

module dma_control (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [7:0]              reg_address,  // register of the current slot
  input  logic [15:0]             data_in,
  input  logic                    blit_busy,
  input  logic                    blit_zero,
  output agnus_pkg::dma_enables_t enables,
  output logic [15:0]             data_out
);

  logic [`AGNUS_DMACON_W-1:0] dmacon;             // stored control bits
  logic                       master;             // global dma enable
  logic                       wr_sel;
  logic                       rd_sel;

  assign wr_sel = (reg_address == `AGNUS_REG_DMACON);
  assign rd_sel = (reg_address == `AGNUS_REG_DMACONR);

  // --------------------
  // write, bit 15 chooses set or clear of the marked bits
  always_ff @(posedge clk) begin
    if (reset) begin
      dmacon <= '0;
    end else if (wr_sel) begin
      if (data_in[`AGNUS_DMA_SETCLR]) begin
        dmacon <= dmacon | data_in[`AGNUS_DMACON_W-1:0];     // set
      end else begin
        dmacon <= dmacon & ~data_in[`AGNUS_DMACON_W-1:0];    // clear
      end
    end
  end

  // --------------------
  // read back, zero on any other register
  assign data_out = rd_sel ? {1'b0, blit_busy, blit_zero, dmacon} : 16'h0000;

  // channel enables all need the master bit, nasty does not
  assign master = dmacon[`AGNUS_DMA_MASTER];
  assign enables = '{
    bpl:    dmacon[`AGNUS_DMA_BPLEN] & master,
    spr:    dmacon[`AGNUS_DMA_SPREN] & master,
    cop:    dmacon[`AGNUS_DMA_COPEN] & master,
    blt:    dmacon[`AGNUS_DMA_BLTEN] & master,
    bltpri: dmacon[`AGNUS_DMA_BLTPRI]
  };

  // marked bits hold the written state one cycle after the write
  wr_takes_effect: assert property (@(posedge clk) disable iff (reset)
    wr_sel |=> ((dmacon & $past(data_in[`AGNUS_DMACON_W-1:0]))
               == ($past(data_in[`AGNUS_DMA_SETCLR]) ? $past(data_in[`AGNUS_DMACON_W-1:0])
                                                    : `AGNUS_DMACON_W'(0))))
    else $error("dmacon write not applied");

endmodule

`default_nettype wire

// ==== beam_counter.sv ====
/*
  horizontal beam counter
  counts bus cycles along a line and decodes refresh slots,
  start of line and the video/audio chip strobes
*/
`timescale 1ns/1ns
`default_nettype none
`include "agnus_cfg.svh"

module beam_counter (
  input  logic                     clk,
  input  logic                     reset,
  output logic [`AGNUS_HPOS_W-1:0] hpos,          // slot position in line
  output logic                     cck,           // colour clock phase
  output logic                     refresh,       // refresh owns this slot
  output logic                     sol,           // last slot of the line
  output logic                     strhor_denise,
  output logic                     strhor_paula
);

  localparam logic [`AGNUS_HPOS_W-1:0] HPOS_LAST = `AGNUS_HPOS_W'(`AGNUS_HTOTAL - 1);
  localparam logic [`AGNUS_HPOS_W-1:0] REF_FIRST = `AGNUS_HPOS_W'(`AGNUS_REFRESH_FIRST);
  localparam logic [`AGNUS_HPOS_W-1:0] REF_LAST  = `AGNUS_HPOS_W'(`AGNUS_REFRESH_LAST);
  localparam logic [`AGNUS_HPOS_W-1:0] POS_DEN   = `AGNUS_HPOS_W'(`AGNUS_STRHOR_DENISE);
  localparam logic [`AGNUS_HPOS_W-1:0] POS_PAU   = `AGNUS_HPOS_W'(`AGNUS_STRHOR_PAULA);

  // --------------------
  // one bus cycle per clk, wrap at end of line
  always_ff @(posedge clk) begin
    if (reset) begin
      hpos <= '0;
    end else if (hpos == HPOS_LAST) begin
      hpos <= '0;                                   // new line
    end else begin
      hpos <= hpos + 1'b1;
    end
  end

  // --------------------
  // fixed slot decode
  assign cck = hpos[0];                             // odd slots belong to chipset
  assign refresh = cck && (hpos >= REF_FIRST) && (hpos <= REF_LAST);
  assign sol = (hpos == HPOS_LAST);
  assign strhor_denise = (hpos == POS_DEN);
  assign strhor_paula = (hpos == POS_PAU);

  // position never leaves the visible line range
  hpos_in_line: assert property (@(posedge clk) disable iff (reset)
    hpos < `AGNUS_HPOS_W'(`AGNUS_HTOTAL))
    else $error("hpos beyond line length");

endmodule

`default_nettype wire

// ==== agnus_pkg.sv ====
/*
  agnus dma core types
  slot owner encoding and the bundles passed between the arbiter blocks
*/
`default_nettype none

package agnus_pkg;

  // --------------------
  // bus slot owner, listed highest priority first
  typedef enum logic [2:0] {
    CH_DSK,
    CH_REF,
    CH_AUD,
    CH_BPL,
    CH_SPR,
    CH_COP,
    CH_BLT,
    CH_CPU
  } chan_e;

  // --------------------
  typedef struct packed {
    logic        aen;          // register bank select
    logic        rd;
    logic        hwr;          // high byte write
    logic        lwr;          // low byte write
    logic [7:0]  address;      // register word address
    logic [15:0] data;         // write data
  } cpu_bus_t;

  typedef struct packed {
    logic dsk;                 // request levels
    logic aud;
    logic bpl;
    logic spr;
    logic cop;
    logic blt;
    logic dsk_wr;              // disk cycle is a memory write
    logic blt_we;              // blitter cycle is a memory write
  } dma_req_t;

  typedef struct packed {
    logic [19:0] address;      // chip ram word address
    logic [7:0]  reg_address;  // target register
  } chan_addr_t;

  typedef struct packed {
    chan_addr_t dsk;
    chan_addr_t aud;
    chan_addr_t bpl;
    chan_addr_t spr;
    chan_addr_t cop;
    chan_addr_t blt;
  } engine_addr_t;

  typedef struct packed {
    logic bpl;                 // enables already qualified by master
    logic spr;
    logic cop;
    logic blt;
    logic bltpri;
  } dma_enables_t;

  typedef struct packed {
    chan_e owner;
    logic  cpu_custom;         // cpu may use chip bus
    logic  dbr;                // chipset holds the data bus
    logic  dbwe;               // chipset memory write
    logic  ack_spr;
    logic  ack_cop;
    logic  ack_blt;
  } bus_grant_t;

endpackage

`default_nettype wire

// ==== agnus_cfg.svh ====
/*
  agnus dma core configuration
  register word addresses, line timing, refresh and strobe slots,
  blitter slowdown limit and the dmacon bit map
*/
`ifndef AGNUS_CFG_SVH
`define AGNUS_CFG_SVH

// register word addresses (byte address >> 1)
`define AGNUS_REG_DMACON    8'h4B   // dmacon write, byte 0x096
`define AGNUS_REG_DMACONR   8'h01   // dmacon read, byte 0x002
`define AGNUS_REG_IDLE      8'hFF   // no register selected

// line timing
`define AGNUS_HPOS_W        9       // horizontal position width
`define AGNUS_HTOTAL        227     // bus cycles per line
`define AGNUS_REFRESH_FIRST 1       // refresh on odd slots first..last
`define AGNUS_REFRESH_LAST  7
`define AGNUS_STRHOR_DENISE 11      // video chip strobe slot
`define AGNUS_STRHOR_PAULA  13      // audio chip strobe slot

`define AGNUS_BLS_CNT_MAX   3       // cpu-lost cycles before blitter blocks

// dmacon bit map
`define AGNUS_DMACON_W      13      // stored bits, 12:0
`define AGNUS_DMA_SETCLR    15
`define AGNUS_DMA_BLTPRI    10      // blitter nasty
`define AGNUS_DMA_MASTER    9
`define AGNUS_DMA_BPLEN     8
`define AGNUS_DMA_COPEN     7
`define AGNUS_DMA_BLTEN     6
`define AGNUS_DMA_SPREN     5

`endif
